/* core_pkg.sv */
`default_nettype none

package core_pkg;

	// ****************************************
	// widths
	// ****************************************
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;

	// major opcodes handled by this datapath
	typedef enum logic [6:0] {
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_lui    = 7'b0110111
	} opcode_e;

	// funct3 for integer register and immediate operations
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// funct7, alt selects sub and sra
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;

	// ****************************************
	// alu operations
	// ****************************************
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
		alu_srl, alu_sra, alu_or, alu_and,
		alu_pass_b
	} alu_op_e;

endpackage

`default_nettype wire

/* instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  instr_valid,
	input  logic [31:0]           instr,
	output logic                  dec_valid,
	output logic                  dec_illegal,
	output alu_op_e               alu_op,
	output logic                  use_imm,
	output logic [xlen-1:0]       imm,
	output logic [reg_addr_w-1:0] rd,
	output logic [reg_addr_w-1:0] r_addr1,
	output logic                  r_ena1,
	output logic [reg_addr_w-1:0] r_addr2,
	output logic                  r_ena2
);

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	alu_op_e         op_nxt;
	logic            use_imm_nxt;
	logic [xlen-1:0] imm_nxt;
	logic            ena1_nxt;
	logic            ena2_nxt;
	logic            bad;

	// plain funct3 mapping, right shift taken as logical
	function automatic alu_op_e base_op(input logic [2:0] f3);
		case (f3)
			f3_add:  base_op = alu_add;
			f3_sll:  base_op = alu_sll;
			f3_slt:  base_op = alu_slt;
			f3_sltu: base_op = alu_sltu;
			f3_xor:  base_op = alu_xor;
			f3_sr:   base_op = alu_srl;
			f3_or:   base_op = alu_or;
			default: base_op = alu_and;
		endcase
	endfunction

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		op_nxt      = base_op(funct3);
		use_imm_nxt = 1'b0;
		imm_nxt     = {{20{instr[31]}}, instr[31:20]};
		ena1_nxt    = 1'b0;
		ena2_nxt    = 1'b0;
		bad         = 1'b0;
		case (opcode)
			opc_op_imm: begin
				ena1_nxt    = 1'b1;
				use_imm_nxt = 1'b1;
				if (funct3 == f3_sll || funct3 == f3_sr) begin
					imm_nxt = {27'b0, instr[24:20]};
					if (funct3 == f3_sr && funct7 == f7_alt)
						op_nxt = alu_sra;
					else if (funct7 != f7_base)
						bad = 1'b1;
				end
			end
			opc_op: begin
				ena1_nxt = 1'b1;
				ena2_nxt = 1'b1;
				if (funct7 == f7_alt && funct3 == f3_add)
					op_nxt = alu_sub;
				else if (funct7 == f7_alt && funct3 == f3_sr)
					op_nxt = alu_sra;
				else if (funct7 != f7_base)
					bad = 1'b1;
			end
			opc_lui: begin
				op_nxt      = alu_pass_b;
				use_imm_nxt = 1'b1;
				imm_nxt     = {instr[31:12], 12'b0};
			end
			default: bad = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid   <= 1'b0;
			dec_illegal <= 1'b0;
			r_ena1      <= 1'b0;
			r_ena2      <= 1'b0;
		end else begin
			dec_valid   <= instr_valid;
			dec_illegal <= instr_valid & bad;
			r_ena1      <= instr_valid & ena1_nxt & ~bad;
			r_ena2      <= instr_valid & ena2_nxt & ~bad;
		end
	end

	always_ff @(posedge clk) begin
		alu_op  <= op_nxt;
		use_imm <= use_imm_nxt;
		imm     <= imm_nxt;
		rd      <= instr[11:7];
		r_addr1 <= instr[19:15];
		r_addr2 <= instr[24:20];
	end

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,

	input  logic [reg_addr_w-1:0] w_addr,
	input  logic [xlen-1:0]       w_data,
	input  logic                  w_ena,

	input  logic [reg_addr_w-1:0] r_addr1,
	output logic [xlen-1:0]       r_data1,
	input  logic                  r_ena1,

	input  logic [reg_addr_w-1:0] r_addr2,
	output logic [xlen-1:0]       r_data2,
	input  logic                  r_ena2
);

	logic [xlen-1:0] regs [num_regs];

	// x0 is never written, so it stays at its reset value
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end else if (w_ena && w_addr != '0) begin
			regs[w_addr] <= w_data;
		end
	end

	// ****************************************
	// read ports with write forwarding
	// ****************************************
	function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr,
			input logic ena);
		if (rst || !ena)
			read_port = '0;
		else if (w_ena && addr == w_addr && addr != '0)
			read_port = w_data;
		else
			read_port = regs[addr];
	endfunction

	always_comb begin
		r_data1 = read_port(r_addr1, r_ena1);
	end

	always_comb begin
		r_data2 = read_port(r_addr2, r_ena2);
	end

endmodule

`default_nettype wire

/* alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  dec_valid,
	input  logic                  dec_illegal,
	input  alu_op_e               alu_op,
	input  logic                  use_imm,
	input  logic [xlen-1:0]       imm,
	input  logic [reg_addr_w-1:0] rd,
	input  logic [xlen-1:0]       rs1_data,
	input  logic [xlen-1:0]       rs2_data,
	output logic                  w_ena,
	output logic [reg_addr_w-1:0] w_addr,
	output logic [xlen-1:0]       w_data,
	output logic                  illegal
);

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [4:0]      shamt;
	logic            lt_signed;
	logic            lt_unsigned;
	logic [xlen-1:0] result;

	assign op_a  = rs1_data;
	assign op_b  = use_imm ? imm : rs2_data;
	assign shamt = op_b[4:0];

	assign lt_signed   = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	// ****************************************
	// operation select
	// ****************************************
	always_comb begin
		case (alu_op)
			alu_add:    result = op_a + op_b;
			alu_sub:    result = op_a - op_b;
			alu_sll:    result = op_a << shamt;
			alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
			alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
			alu_xor:    result = op_a ^ op_b;
			alu_srl:    result = op_a >> shamt;
			alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
			alu_or:     result = op_a | op_b;
			alu_and:    result = op_a & op_b;
			alu_pass_b: result = op_b;
			default:    result = '0;
		endcase
	end

	// writeback registers
	always_ff @(posedge clk) begin
		if (rst) begin
			w_ena   <= 1'b0;
			illegal <= 1'b0;
		end else begin
			w_ena   <= dec_valid & ~dec_illegal;
			illegal <= dec_valid & dec_illegal;
		end
	end

	always_ff @(posedge clk) begin
		w_addr <= rd;
		w_data <= result;
	end

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  instr_valid,
	input  logic [31:0]           instr,
	output logic                  wb_en,
	output logic [reg_addr_w-1:0] wb_addr,
	output logic [xlen-1:0]       wb_data,
	output logic                  illegal
);

	logic                  dec_valid;
	logic                  dec_illegal;
	alu_op_e               alu_op;
	logic                  use_imm;
	logic [xlen-1:0]       imm;
	logic [reg_addr_w-1:0] rd;
	logic [reg_addr_w-1:0] r_addr1;
	logic                  r_ena1;
	logic [reg_addr_w-1:0] r_addr2;
	logic                  r_ena2;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;

	// ****************************************
	// decode, register read, execute
	// ****************************************
	instr_decode instr_decode_inst (
		.clk, .rst, .instr_valid, .instr,
		.dec_valid, .dec_illegal, .alu_op, .use_imm, .imm, .rd,
		.r_addr1, .r_ena1, .r_addr2, .r_ena2
	);

	regfile regfile_inst (
		.clk, .rst,
		.w_addr(wb_addr), .w_data(wb_data), .w_ena(wb_en),
		.r_addr1, .r_data1(rs1_data), .r_ena1,
		.r_addr2, .r_data2(rs2_data), .r_ena2
	);

	// writeback registers double as the register file write port
	alu_exec alu_exec_inst (
		.clk, .rst, .dec_valid, .dec_illegal, .alu_op, .use_imm, .imm, .rd,
		.rs1_data, .rs2_data,
		.w_ena(wb_en), .w_addr(wb_addr), .w_data(wb_data), .illegal
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	// 100 ns period
	initial clk = 1'b0;
	always #50 clk = ~clk;

endmodule

`default_nettype wire

/* tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core import core_pkg::*; ();

	logic                  clk;
	logic                  rst;
	logic                  instr_valid;
	logic [31:0]           instr;
	logic                  wb_en;
	logic [reg_addr_w-1:0] wb_addr;
	logic [xlen-1:0]       wb_data;
	logic                  illegal;

	// reference register file and expected writebacks {en, illegal, addr, data}
	logic [xlen-1:0] model_regs [num_regs];
	logic [38:0]     exp_q [$];
	string           exp_name [$];
	logic [31:0]     rng_state;
	int              mismatches;
	int              timeouts;

	tb_clock tb_clock_inst (.clk(clk));

	core_top core_top_inst (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data), .illegal(illegal)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic draw(output logic [31:0] v);
		rng_state = xorshift32(rng_state);
		v = rng_state;
	endtask

	// ****************************************
	// RV32I reference
	// ****************************************
	task automatic reference(input logic [31:0] ins, output logic legal,
			output logic [xlen-1:0] res);
		logic [2:0]      f3;
		logic [6:0]      f7;
		logic            is_op;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		f3    = ins[14:12];
		f7    = ins[31:25];
		is_op = ins[6:0] == opc_op;
		a     = model_regs[ins[19:15]];
		b     = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
		legal = 1'b1;
		if (ins[6:0] == opc_lui)
			b = {ins[31:12], 12'b0};
		else if (!is_op && ins[6:0] != opc_op_imm)
			legal = 1'b0;
		else if (f3 == f3_sll && f7 != f7_base)
			legal = 1'b0;
		else if ((f3 == f3_sr || (is_op && f3 == f3_add)) && f7 != f7_base && f7 != f7_alt)
			legal = 1'b0;
		else if (is_op && f3 != f3_add && f3 != f3_sr && f7 != f7_base)
			legal = 1'b0;
		case (f3)
			f3_add:  res = (is_op && f7[5]) ? a - b : a + b;
			f3_sll:  res = a << b[4:0];
			f3_slt:  res = {31'b0, $signed(a) < $signed(b)};
			f3_sltu: res = {31'b0, a < b};
			f3_xor:  res = a ^ b;
			f3_sr:   res = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			f3_or:   res = a | b;
			default: res = a & b;
		endcase
		if (ins[6:0] == opc_lui)
			res = b;
	endtask

	// random legal OP or OP-IMM instruction
	function automatic logic [31:0] rand_alu(input logic [31:0] r, input logic is_op);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = r[2:0];
		f7 = (r[3] && (f3 == f3_sr || (is_op && f3 == f3_add))) ? f7_alt : f7_base;
		if (is_op)
			return {f7, r[18:14], r[8:4], f3, r[13:9], opc_op};
		if (f3 == f3_sll || f3 == f3_sr)
			return {f7, r[24:20], r[8:4], f3, r[13:9], opc_op_imm};
		return {r[31:20], r[8:4], f3, r[13:9], opc_op_imm};
	endfunction

	function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [4:0] rd);
		return {imm, rs1, f3_add, rd, opc_op_imm};
	endfunction

	function automatic logic pending();
		logic busy;
		busy = 1'b0;
		foreach (exp_q[i])
			busy = busy | exp_q[i][38] | exp_q[i][37];
		return busy;
	endfunction

	// drive one cycle, then check the writeback of the instruction driven two cycles earlier
	task automatic issue(input logic v, input logic [31:0] ins, input string name);
		logic            legal;
		logic [xlen-1:0] res;
		logic [38:0]     head;
		string           head_name;
		@(posedge clk);
		instr_valid <= v;
		instr       <= ins;
		reference(ins, legal, res);
		exp_q.push_back({v && legal, v && !legal, ins[11:7], res});
		exp_name.push_back(name);
		if (v && legal && ins[11:7] != 5'd0)
			model_regs[ins[11:7]] = res;
		@(negedge clk);
		head      = exp_q.pop_front();
		head_name = exp_name.pop_front();
		if (wb_en !== head[38]) begin
			$display("FAILED %s wb_en expected %0b actual %0b", head_name, head[38], wb_en);
			mismatches++;
		end
		if (illegal !== head[37]) begin
			$display("FAILED %s illegal expected %0b actual %0b", head_name, head[37], illegal);
			mismatches++;
		end
		if (head[38] && wb_addr !== head[36:32]) begin
			$display("FAILED %s wb_addr expected %0d actual %0d", head_name, head[36:32], wb_addr);
			mismatches++;
		end
		if (head[38] && wb_data !== head[31:0]) begin
			$display("FAILED %s wb_data expected %h actual %h", head_name, head[31:0], wb_data);
			mismatches++;
		end
	endtask

	initial begin
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
	end

	initial begin : main
		logic [31:0] r;
		logic [31:0] g;
		logic [31:0] ins;
		logic [4:0]  prev_rd;
		int          cnt;
		rng_state  = 32'hbc8f;
		mismatches = 0;
		timeouts   = 0;
		for (int i = 0; i < num_regs; i++)
			model_regs[i] = '0;
		// two cycles in flight, idle before the first issue
		exp_q    = '{39'd0, 39'd0};
		exp_name = '{"reset", "reset"};
		cnt = 0;
		while (rst !== 1'b0 && cnt < 40) begin
			@(posedge clk);
			cnt++;
		end
		if (rst !== 1'b0) begin
			$display("timeout while waiting for reset release");
			timeouts++;
		end

		repeat (8)
			issue(1'b0, 32'h0, "reset_idle");
		for (int i = 0; i < num_regs; i++)
			issue(1'b1, enc_addi(12'h0, i[4:0], i[4:0]), "reset_read");

		repeat (300) begin
			draw(r);
			draw(g);
			issue(g[2:0] != 3'd0, rand_alu(r, 1'b0), "op_imm");
		end
		repeat (300) begin
			draw(r);
			draw(g);
			ins = g[4:3] == 2'd0 ? {r[31:12], r[11:7], opc_lui} : rand_alu(r, 1'b1);
			issue(g[2:0] != 3'd0, ins, "op_lui");
		end

		// ****************************************
		// dependent chains, one per cycle
		// ****************************************
		prev_rd = 5'd1;
		repeat (200) begin
			draw(r);
			draw(g);
			ins = rand_alu(r, g[0]);
			ins[19:15] = prev_rd;
			if (g[0] && g[1])
				ins[24:20] = prev_rd;
			if (ins[11:7] == 5'd0)
				ins[11:7] = 5'd9;
			prev_rd = ins[11:7];
			issue(1'b1, ins, "chain");
		end

		// x0 write goes out on the writeback but is not forwarded or stored
		repeat (20) begin
			draw(r);
			ins = rand_alu(r, r[19]);
			ins[11:7] = 5'd0;
			issue(1'b1, ins, "x0_write");
			issue(1'b1, enc_addi(r[31:20], 5'd0, r[13:9]), "x0_read");
		end

		repeat (80) begin
			draw(r);
			draw(g);
			ins = r;
			case (g[1:0])
				2'd0: ins[6] = 1'b1;
				2'd1: begin
					ins = rand_alu(r, 1'b1);
					ins[25] = 1'b1;
				end
				2'd2: begin
					ins = rand_alu(r, 1'b0);
					ins[14:12] = g[2] ? f3_sll : f3_sr;
					ins[25] = 1'b1;
				end
				default: ins = rand_alu(r, g[2]);
			endcase
			issue(1'b1, ins, "illegal");
		end

		for (int i = 0; i < num_regs; i++)
			issue(1'b1, enc_addi(12'h0, i[4:0], i[4:0]), "final_read");

		cnt = 0;
		while (pending() && cnt < 8) begin
			issue(1'b0, 32'h0, "drain");
			cnt++;
		end
		if (pending()) begin
			$display("timeout while draining the writebacks");
			timeouts++;
		end

		$display("mismatches %0d, timeouts %0d", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
core_pkg.sv
instr_decode.sv
regfile.sv
alu_exec.sv
core_top.sv
tb_clock.sv
tb_core.sv

/* run.sh */
#!/bin/sh
# build the core testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_core \
	-f vlog.f -o tb_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$log"; then
	echo "pass message not found in $log"
	exit 1
fi
exit 0
